// ==== mesh_router_pkg.sv ====
package mesh_router_pkg;

    // ----------------------------------------------------------
    // Mesh geometry
    // ----------------------------------------------------------

    localparam int COORD_WIDTH = 4;          // Up to 16 nodes per axis
    localparam int NUM_PORTS   = 5;          // Local port plus four neighbours

    typedef logic [COORD_WIDTH-1:0]   coord_t;      // One axis position
    typedef logic [2*COORD_WIDTH-1:0] node_addr_t;  // {y, x}

    // ----------------------------------------------------------
    // Beat format
    // ----------------------------------------------------------

    // One symbol per beat, head beat payload is the destination
    typedef logic [7:0] flit_data_t;

    typedef struct packed {
        flit_data_t data;   // Payload or destination address
        logic       sop;    // First beat of packet
        logic       eop;    // Last beat of packet
    } flit_t;

    // ----------------------------------------------------------
    // Output port selection
    // ----------------------------------------------------------

    // Encoding doubles as the output port index
    typedef enum logic [2:0] {
        HERE  = 3'd0,
        NORTH = 3'd1,
        SOUTH = 3'd2,
        EAST  = 3'd3,
        WEST  = 3'd4
    } direction_t;

    typedef logic [NUM_PORTS-1:0] port_mask_t;  // One bit per output port

endpackage

// ==== route_compute.sv ====
`timescale 1ns/1ps

module route_compute import mesh_router_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  node_addr_t node_addr,   // Strapped position of this node
    input  flit_data_t head_data,   // Payload of the incoming beat
    input  logic       head,        // Accepted beat is a packet head
    output direction_t route_dir
);

    coord_t     node_y;
    coord_t     node_x;
    coord_t     dest_y;
    coord_t     dest_x;
    direction_t decision;           // Fresh result for the current beat
    direction_t packet_dir;         // Held for the rest of the packet

    // High half is y, low half is x
    always_comb begin
        {node_y, node_x} = node_addr;
        {dest_y, dest_x} = head_data;
    end

    // ----------------------------------------------------------
    // Dimension-ordered decision, origin at the top left
    // ----------------------------------------------------------
    always_comb begin
        if (dest_y == node_y && dest_x == node_x) begin
            decision = HERE;        // Arrived
        end else if (dest_y < node_y) begin
            decision = NORTH;
        end else if (dest_x > node_x) begin
            decision = EAST;
        end else if (dest_y > node_y) begin
            decision = SOUTH;
        end else begin
            decision = WEST;        // Same row, smaller x
        end
    end

    // Only a head beat updates the packet direction
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            packet_dir <= HERE;
        end else if (head) begin
            packet_dir <= decision;
        end
    end

    // Head beat uses its own decision, body beats the held one
    assign route_dir = head ? decision : packet_dir;

endmodule

// ==== packet_fsm.sv ====
`timescale 1ns/1ps

module packet_fsm import mesh_router_pkg::*; (
    input  logic clk,
    input  logic reset_n,
    input  logic accept,        // Beat transfers this cycle
    input  logic sop,
    input  logic eop,
    output logic head,          // Accepted beat opens a packet
    output logic keep,          // Accepted beat goes to the output stage
    output logic framing_error  // One-cycle pulse after a bad beat
);

    typedef enum logic {
        IDLE,
        IN_PACKET
    } state_t;

    state_t state;
    state_t state_next;
    logic   bad_beat;

    // ----------------------------------------------------------
    // Accept-side decode
    // ----------------------------------------------------------

    // Any sop starts a packet, even inside an open one
    assign head = accept && sop;

    // Outside a packet only a head is kept
    assign keep = accept && (sop || state == IN_PACKET);

    always_comb begin
        bad_beat = 1'b0;
        if (accept) begin
            case (state)
                IDLE:      bad_beat = !sop;  // Stray beat, dropped
                IN_PACKET: bad_beat = sop;   // Restart of open packet
                default:   bad_beat = 1'b0;
            endcase
        end
    end

    // Next state
    always_comb begin
        state_next = state;
        if (keep) begin
            // Closing beat ends the packet, anything else leaves it open
            state_next = eop ? IDLE : IN_PACKET;
        end
    end

    // ----------------------------------------------------------
    // State and error pulse
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state         <= IDLE;
            framing_error <= 1'b0;
        end else begin
            state         <= state_next;
            framing_error <= bad_beat;  // Clears itself next cycle
        end
    end

endmodule

// ==== beat_counter.sv ====
`timescale 1ns/1ps

module beat_counter import mesh_router_pkg::*; #(
    parameter int PACKET_BEATS = 7
) (
    input  logic clk,
    input  logic reset_n,
    input  logic accept,
    input  logic keep,
    input  logic head,
    input  logic eop,
    output logic length_error   // One-cycle pulse after a bad-length eop
);

    // Room for PACKET_BEATS + 1 so an overlong packet never wraps to a match
    localparam int COUNT_WIDTH = $clog2(PACKET_BEATS + 2);

    localparam logic [COUNT_WIDTH-1:0] COUNT_MAX = '1;
    localparam logic [COUNT_WIDTH-1:0] EXPECTED  = COUNT_WIDTH'(PACKET_BEATS);

    logic                   kept;       // Beat reaches the output stage
    logic [COUNT_WIDTH-1:0] count;      // Beats of the open packet so far
    logic [COUNT_WIDTH-1:0] beat_total; // Count including this beat

    assign kept = accept && keep;

    // Head restarts at one, other beats add one up to the ceiling
    always_comb begin
        if (head) begin
            beat_total = COUNT_WIDTH'(1);
        end else if (count == COUNT_MAX) begin
            beat_total = COUNT_MAX;
        end else begin
            beat_total = count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            count        <= '0;
            length_error <= 1'b0;
        end else begin
            length_error <= kept && eop && (beat_total != EXPECTED);
            if (kept) begin
                count <= beat_total;
            end
        end
    end

endmodule

// ==== route_stage.sv ====
`timescale 1ns/1ps

module route_stage import mesh_router_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,

    // Upstream side
    input  logic       in_valid,
    input  flit_t      in_flit,
    input  logic       keep,        // Load this beat, else consume and drop
    input  direction_t route_dir,   // Port for the incoming beat
    output logic       in_ready,
    output logic       accept,      // Beat transfers on the input

    // Downstream side
    output port_mask_t out_valid,   // At most one bit set
    input  port_mask_t out_ready,
    output flit_t      out_flit     // Shared by all five ports
);

    logic       full;               // Stage holds a beat
    flit_t      held_flit;
    direction_t held_dir;           // Port the held beat leaves on
    logic       port_ready;         // Selected port can take the beat
    logic       leaving;            // Held beat transfers this cycle
    logic       load;

    // ----------------------------------------------------------
    // Handshake
    // ----------------------------------------------------------

    // Only the port selected by the held beat matters
    assign port_ready = out_ready[held_dir];

    // Empty, or the current beat leaves in this same cycle
    assign in_ready = !full || port_ready;

    assign accept  = in_valid && in_ready;
    assign leaving = full && port_ready;
    assign load    = accept && keep;        // Dropped beats leave no trace

    // ----------------------------------------------------------
    // Control state
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            full     <= 1'b0;
            held_dir <= HERE;
        end else if (load) begin
            full     <= 1'b1;                   // Refill wins over drain
            held_dir <= route_dir;
        end else if (leaving) begin
            full     <= 1'b0;
        end
    end

    // Payload register
    always_ff @(posedge clk) begin
        if (load) begin
            held_flit <= in_flit;
        end
    end

    // ----------------------------------------------------------
    // Steering
    // ----------------------------------------------------------

    // Held direction decoded one-hot, nothing when empty
    always_comb begin
        out_valid = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            out_valid[p] = full && (held_dir == direction_t'(p));
        end
    end

    assign out_flit = held_flit;    // Qualified by out_valid

endmodule

// ==== mesh_router.sv ====
`timescale 1ns/1ps

module mesh_router import mesh_router_pkg::*; #(
    parameter int PACKET_BEATS = 7
) (
    input  logic       clk,
    input  logic       reset_n,
    input  node_addr_t node_addr,   // Strapped {y, x} of this node

    // Input channel
    input  logic       in_valid,
    output logic       in_ready,
    input  flit_t      in_flit,

    // Five output ports over one shared flit bus
    output port_mask_t out_valid,
    input  port_mask_t out_ready,
    output flit_t      out_flit,

    // Error pulses
    output logic       length_error,
    output logic       framing_error
);

    logic       accept;     // Input transfer
    logic       head;       // Accepted beat carries sop
    logic       keep;       // Accepted beat is forwarded
    direction_t route_dir;

    // ----------------------------------------------------------
    // Routing decision
    // ----------------------------------------------------------
    route_compute route_compute_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .node_addr (node_addr),
        .head_data (in_flit.data),
        .head      (head),
        .route_dir (route_dir)
    );

    // Framing and length checks
    packet_fsm packet_fsm_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .accept        (accept),
        .sop           (in_flit.sop),
        .eop           (in_flit.eop),
        .head          (head),
        .keep          (keep),
        .framing_error (framing_error)
    );

    beat_counter #(
        .PACKET_BEATS (PACKET_BEATS)
    ) beat_counter_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .accept       (accept),
        .keep         (keep),
        .head         (head),
        .eop          (in_flit.eop),
        .length_error (length_error)
    );

    // ----------------------------------------------------------
    // Output register and port steering
    // ----------------------------------------------------------
    route_stage route_stage_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (in_valid),
        .in_flit   (in_flit),
        .keep      (keep),
        .route_dir (route_dir),
        .in_ready  (in_ready),
        .accept    (accept),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_flit  (out_flit)
    );

endmodule

// ==== tb_router_checker.sv ====
`timescale 1ns/1ps

module tb_router_checker import mesh_router_pkg::*; #(
    parameter int PACKET_BEATS = 7
) (
    input  logic       clk,
    input  logic       reset_n,
    input  node_addr_t node_addr,
    input  logic       in_valid,
    input  logic       in_ready,
    input  flit_t      in_flit,
    input  port_mask_t out_valid,
    input  port_mask_t out_ready,
    input  flit_t      out_flit,
    input  logic       length_error,
    input  logic       framing_error,
    input  logic       test_done,     // One-cycle strobe from the stimulus
    input  int         test_num,
    output int         pending,       // Beats still owed on the outputs
    output int         tests_passed,
    output int         tests_failed,
    output int         error_total
);

    flit_t      exp_flit_q[$];        // Kept beats in arrival order
    direction_t exp_dir_q[$];         // Port each of them must leave on
    logic       in_packet;            // Framing model state
    direction_t pkt_dir;
    int         beat_count;
    logic       exp_framing;          // Pulses due in the coming cycle
    logic       exp_length;
    logic       reset_seen;
    int         test_errors;

    initial begin
        pending      = 0;
        tests_passed = 0;
        tests_failed = 0;
        error_total  = 0;
        test_errors  = 0;
        reset_seen   = 1'b0;
    end

    // ----------------------------------------------------------
    // Reference routing rule with y in the high nibble
    // ----------------------------------------------------------
    function automatic direction_t predict_route(input node_addr_t node, input flit_data_t dest);
        if (dest == node) return HERE;
        if (dest[7:4] < node[7:4]) return NORTH;
        if (dest[3:0] > node[3:0]) return EAST;   // x before the southward move
        if (dest[7:4] > node[7:4]) return SOUTH;
        return WEST;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Mismatch at %0d ns: %s expected %0h got %0h", $time, name, expected, actual);
        test_errors++;
        error_total++;
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0d ns: %s", $time, what);
        test_errors++;
        error_total++;
    endtask

    // Outputs stay quiet through reset
    task automatic check_quiet();
        if (out_valid !== '0) report_mismatch("out_valid", 0, out_valid);
        if (length_error !== 1'b0) report_mismatch("length_error", 0, length_error);
        if (framing_error !== 1'b0) report_mismatch("framing_error", 0, framing_error);
    endtask

    task automatic check_errors();
        if (framing_error !== exp_framing)
            report_mismatch("framing_error", exp_framing, framing_error);
        if (length_error !== exp_length)
            report_mismatch("length_error", exp_length, length_error);
    endtask

    // ----------------------------------------------------------
    // Output side against a one-beat stage model
    // ----------------------------------------------------------

    // Queue head is the beat the stage must hold right now
    task automatic check_outputs();
        port_mask_t exp_valid;
        logic       exp_ready;
        exp_valid = '0;
        exp_ready = 1'b1;                           // Empty stage takes any beat
        if (exp_flit_q.size() != 0) begin
            exp_valid[exp_dir_q[0]] = 1'b1;         // Only the predicted port
            exp_ready = out_ready[exp_dir_q[0]];    // Drains or stays blocked
        end
        if (out_valid !== exp_valid) report_mismatch("out_valid", exp_valid, out_valid);
        if (in_ready !== exp_ready) report_mismatch("in_ready", exp_ready, in_ready);
        if (exp_flit_q.size() != 0) begin
            // Same flit every cycle until it transfers
            if (out_flit !== exp_flit_q[0])
                report_mismatch("out_flit", exp_flit_q[0], out_flit);
            if (exp_ready) begin
                void'(exp_flit_q.pop_front());
                void'(exp_dir_q.pop_front());
            end
        end
    endtask

    // ----------------------------------------------------------
    // Input side framing and length model
    // ----------------------------------------------------------
    task automatic model_input();
        logic kept;
        kept        = 1'b0;
        exp_framing = 1'b0;
        exp_length  = 1'b0;
        if (in_valid && in_ready) begin
            if (in_flit.sop) begin
                exp_framing = in_packet;            // Restart of an open packet
                pkt_dir     = predict_route(node_addr, in_flit.data);
                beat_count  = 1;
                kept        = 1'b1;
            end else if (!in_packet) begin
                exp_framing = 1'b1;                 // Stray beat is dropped
            end else begin
                beat_count++;
                kept = 1'b1;
            end
            if (kept) begin
                exp_flit_q.push_back(in_flit);
                exp_dir_q.push_back(pkt_dir);
                in_packet = !in_flit.eop;
                if (in_flit.eop && beat_count != PACKET_BEATS) exp_length = 1'b1;
            end
        end
    endtask

    task automatic report_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("Test %0d passed", test_num);
        end else begin
            tests_failed++;
            $display("Test %0d failed with %0d errors", test_num, test_errors);
        end
        test_errors = 0;
    endtask

    always @(posedge clk) begin
        if (!reset_n) begin
            if (reset_seen) check_quiet();        // First edge still sees X
            reset_seen  = 1'b1;
            in_packet   = 1'b0;
            pkt_dir     = HERE;
            beat_count  = 0;
            exp_framing = 1'b0;
            exp_length  = 1'b0;
            exp_flit_q.delete();
            exp_dir_q.delete();
        end else begin
            check_errors();
            check_outputs();
            model_input();
            if (test_done) report_test();
        end
        pending <= exp_flit_q.size();
    end

endmodule

// ==== tb_mesh_router.sv ====
`timescale 1ns/1ps

module tb_mesh_router import mesh_router_pkg::*; ();

    localparam int PACKET_BEATS  = 7;
    localparam int RESET_CYCLES  = 16;
    localparam int NUM_TESTS     = 16;
    localparam int READY_TIMEOUT = 200;   // Cycles per beat
    localparam int DRAIN_TIMEOUT = 400;   // Cycles per packet drain

    // One row per packet
    typedef struct packed {
        coord_t     dest_y;
        coord_t     dest_x;
        logic [7:0] beats;
        logic       no_sop;       // Stray beats with no head at all
        logic       mid_sop;      // Second head halfway through
        logic       rand_ready;   // Random back-pressure on the outputs
    } test_row_t;

    logic        clk;
    logic        reset_n;
    node_addr_t  node_addr;
    logic        in_valid;
    logic        in_ready;
    flit_t       in_flit;
    port_mask_t  out_valid;
    port_mask_t  out_ready;
    flit_t       out_flit;
    logic        length_error;
    logic        framing_error;

    test_row_t   tests [NUM_TESTS];
    logic        random_ready;
    logic        test_done;
    int          test_num;
    int          seed;
    logic [31:0] rand_word;
    logic        timed_out;
    int          pending;
    int          tests_passed;
    int          tests_failed;
    int          error_total;

    mesh_router #(
        .PACKET_BEATS (PACKET_BEATS)
    ) dut_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .node_addr     (node_addr),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_flit       (in_flit),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_flit      (out_flit),
        .length_error  (length_error),
        .framing_error (framing_error)
    );

    tb_router_checker #(
        .PACKET_BEATS (PACKET_BEATS)
    ) checker_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .node_addr     (node_addr),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_flit       (in_flit),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_flit      (out_flit),
        .length_error  (length_error),
        .framing_error (framing_error),
        .test_done     (test_done),
        .test_num      (test_num),
        .pending       (pending),
        .tests_passed  (tests_passed),
        .tests_failed  (tests_failed),
        .error_total   (error_total)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;             // 40 ns period
    end

    // Downstream ready is all ones unless the row asks for noise
    always @(posedge clk) begin
        rand_word = $random(seed);
        out_ready <= random_ready ? rand_word[NUM_PORTS-1:0] : '1;
    end

    // ----------------------------------------------------------
    // Packet table for a node at y 5 and x 5
    // ----------------------------------------------------------
    task automatic load_table();
        tests[0]  = {4'd5, 4'd5,  8'd7, 1'b0, 1'b0, 1'b0};  // Here
        tests[1]  = {4'd2, 4'd5,  8'd7, 1'b0, 1'b0, 1'b0};  // North
        tests[2]  = {4'd9, 4'd5,  8'd7, 1'b0, 1'b0, 1'b0};  // South
        tests[3]  = {4'd5, 4'd9,  8'd7, 1'b0, 1'b0, 1'b0};  // East
        tests[4]  = {4'd5, 4'd1,  8'd7, 1'b0, 1'b0, 1'b0};  // West
        tests[5]  = {4'd2, 4'd9,  8'd7, 1'b0, 1'b0, 1'b0};  // North wins over east
        tests[6]  = {4'd9, 4'd9,  8'd7, 1'b0, 1'b0, 1'b0};  // East wins over south
        tests[7]  = {4'd9, 4'd1,  8'd7, 1'b0, 1'b0, 1'b0};  // South wins over west
        tests[8]  = {4'd1, 4'd1,  8'd7, 1'b0, 1'b0, 1'b1};
        tests[9]  = {4'd5, 4'd12, 8'd7, 1'b0, 1'b0, 1'b1};
        tests[10] = {4'd9, 4'd5,  8'd3, 1'b0, 1'b0, 1'b0};  // Short packet
        tests[11] = {4'd5, 4'd1,  8'd9, 1'b0, 1'b0, 1'b1};  // Long packet
        tests[12] = {4'd5, 4'd5,  8'd3, 1'b1, 1'b0, 1'b0};  // Stray beats
        tests[13] = {4'd5, 4'd9,  8'd7, 1'b0, 1'b1, 1'b0};  // Restart turns east into south
        tests[14] = {4'd0, 4'd15, 8'd1, 1'b0, 1'b0, 1'b1};  // Lone sop and eop
        tests[15] = {4'd5, 4'd5,  8'd7, 1'b0, 1'b0, 1'b1};
    endtask

    // Head carries {y, x} and a mid-packet head swaps the two
    function automatic flit_t make_beat(input test_row_t row, input int idx, input int k);
        flit_t beat;
        beat.data = {idx[3:0], k[3:0]};
        beat.sop  = (k == 0) && !row.no_sop;
        beat.eop  = (k == row.beats - 1);
        if (beat.sop) beat.data = {row.dest_y, row.dest_x};
        if (row.mid_sop && k == row.beats / 2) begin
            beat.sop  = 1'b1;
            beat.data = {row.dest_x, row.dest_y};
        end
        return beat;
    endfunction

    // ----------------------------------------------------------
    // Drivers with bounded waits
    // ----------------------------------------------------------
    task automatic send_beat(input flit_t beat, input int idx);
        int   waited;
        logic done;
        waited   = 0;
        done     = 1'b0;
        in_valid <= 1'b1;
        in_flit  <= beat;
        while (!done && !timed_out) begin
            @(posedge clk);
            if (in_ready) begin
                done = 1'b1;                    // Transferred at this edge
            end else begin
                waited++;
                if (waited >= READY_TIMEOUT) begin
                    $display("Test %0d timed out: in_ready stayed low for %0d cycles",
                             idx, waited);
                    timed_out = 1'b1;
                end
            end
        end
    endtask

    task automatic drain_outputs(input int idx);
        int waited;
        waited = 0;
        @(posedge clk);                         // Let the last push show up
        while (pending != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (pending != 0) begin
            $display("Test %0d timed out: %0d beats never left the router", idx, pending);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_test(input int idx);
        test_row_t row;
        int        k;
        row          = tests[idx];
        test_num     <= idx;
        random_ready <= row.rand_ready;
        for (k = 0; k < row.beats && !timed_out; k++) begin
            send_beat(make_beat(row, idx, k), idx);
        end
        in_valid <= 1'b0;
        if (!timed_out) drain_outputs(idx);
        if (!timed_out) begin
            @(posedge clk);                     // Room for the last error pulse
            test_done <= 1'b1;
            @(posedge clk);
            test_done <= 1'b0;
        end
    endtask

    initial begin
        reset_n      = 1'b0;
        node_addr    = 8'h55;
        in_valid     = 1'b0;
        in_flit      = '0;
        out_ready    = '1;
        random_ready = 1'b0;
        test_done    = 1'b0;
        test_num     = 0;
        seed         = 32'hf03e3140;
        timed_out    = 1'b0;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < NUM_TESTS && !timed_out; i++) begin
            run_test(i);
        end
        repeat (2) @(posedge clk);
        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_total);
        if (timed_out || tests_failed != 0 || error_total != 0) begin
            $display("SOME TESTS FAILED");
        end else begin
            $display("ALL TESTS PASSED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
mesh_router_pkg.sv
route_compute.sv
packet_fsm.sv
beat_counter.sv
route_stage.sv
mesh_router.sv
tb_router_checker.sv
tb_mesh_router.sv

// ==== Bender.yml ====
package:
  name: mesh_router

sources:
  - mesh_router_pkg.sv
  - route_compute.sv
  - packet_fsm.sv
  - beat_counter.sv
  - route_stage.sv
  - mesh_router.sv
  - target: test
    files:
      - tb_router_checker.sv
      - tb_mesh_router.sv
